/* compile.f */
+incdir+include
source/blitter_pkg.sv
source/bltRegFile.sv
source/bltAddrGen.sv
source/bltSkewBuf.sv
source/bltSequencer.sv
source/bltLogicOp.sv
source/stBlitterTop.sv
dv/bltTbMem.sv
dv/bltTb.sv

/* Bender.yml */
package:
  name: st_blitter

sources:
  - include_dirs:
      - include
    files:
      - source/blitter_pkg.sv
      - source/bltRegFile.sv
      - source/bltAddrGen.sv
      - source/bltSkewBuf.sv
      - source/bltSequencer.sv
      - source/bltLogicOp.sv
      - source/stBlitterTop.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - dv/bltTbMem.sv
      - dv/bltTb.sv

/* dv/bltTb.sv */
/* Blitter testbench top
   Clock and reset, register read-back checks, blit stimulus table
   applied in a loop, word, control word and flag compare tasks */
`include "blitter_cfg.svh"

module bltTb;
	typedef struct packed {
		logic [15:0] srcXinc, srcYinc, dstXinc, dstYinc;
		logic [15:0] maskL, maskC, maskR;
		logic [15:0] hopop;					// HOP in 9:8, OP in 3:0
		logic [3:0] lineNum, skew;
		logic [15:0] xCount, yCount;
		logic [`BLT_ADDR_W-1:0] srcBase, dstBase;
		logic [0:3][15:0] src, dst, ht;	// Words in walk order, halftone 0..3
		logic [0:3][15:0] expDst;
		logic [`BLT_ADDR_W-1:0] expSrcEnd, expDstEnd;
		logic [3:0] expLine;
	} blitRow;

	logic Clks;
	logic reset;
	blitter_pkg::bltRegReq regReq;
	logic [`BLT_DATA_W-1:0] regRdata;
	blitter_pkg::bltMemReq memReq;
	logic memAck;
	logic [`BLT_DATA_W-1:0] memRdata;
	logic busy;
	int errors;
	int checks;
	blitRow rows [7];
	logic [0:13][36:0] regTab;				// {index, write value, read-back}

	stBlitterTop uut (.Clks, .reset, .regReq, .regRdata, .memReq, .memAck, .memRdata, .busy);
	bltTbMem mem (.Clks, .memReq, .memAck, .memRdata);

	initial begin
		Clks = 1'b0;
		forever #20 Clks = ~Clks;
	end

	task automatic writeReg(input logic [4:0] idx, input logic [15:0] data);
		@(posedge Clks);
		#2 regReq = '{wr: 1'b1, rd: 1'b0, idx: idx, wdata: data};
		@(posedge Clks);
		#2 regReq = '0;
	endtask

	// Data is registered, valid one cycle after the strobe
	task automatic readReg(input logic [4:0] idx, output logic [15:0] data);
		@(posedge Clks);
		#2 regReq = '{wr: 1'b0, rd: 1'b1, idx: idx, wdata: 16'h0};
		@(posedge Clks);
		#2 regReq = '0;
		data = regRdata;
	endtask

	task automatic checkWord(input string what, input logic [15:0] got, input logic [15:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic checkCtrl(input blitter_pkg::bltCtrlWord got,
			input blitter_pkg::bltCtrlWord exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: control busy %b line %h skew %h, expected %b %h %h",
				$time, got.f.busy, got.f.lineNum, got.f.skew, exp.f.busy, exp.f.lineNum, exp.f.skew);
		end
	endtask

	// Single status pin
	task automatic checkFlag(input string what, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	// Address of word k: X increment inside a line, Y increment after its last word
	function automatic logic [`BLT_ADDR_W-1:0] walkAddr(input logic [`BLT_ADDR_W-1:0] base,
			input logic [15:0] xInc, input logic [15:0] yInc, input int nx, input int k);
		logic [`BLT_ADDR_W-1:0] a;
		logic [15:0] inc;
		a = base;
		for (int i = 0; i < k; i++) begin
			inc = (i % nx == nx - 1) ? yInc : xInc;
			a = a + {{(`BLT_ADDR_W-16){inc[15]}}, inc};	// Signed step
		end
		return a;
	endfunction

	task automatic runRow(input int n, output logic hung);
		blitRow r;
		logic [15:0] data;
		blitter_pkg::bltCtrlWord ctrl;
		blitter_pkg::bltCtrlWord expCtrl;
		int polls;
		int words;
		hung = 1'b0;
		r = rows[n];
		words = int'(r.xCount) * int'(r.yCount);
		for (int k = 0; k < words; k++) begin
			mem.poke(walkAddr(r.srcBase, r.srcXinc, r.srcYinc, int'(r.xCount), k), r.src[k]);
			mem.poke(walkAddr(r.dstBase, r.dstXinc, r.dstYinc, int'(r.xCount), k), r.dst[k]);
		end
		for (int k = 0; k < 4; k++)
			writeReg(5'(k), r.ht[k]);
		writeReg(`BLT_REG_SRC_XINC, r.srcXinc);
		writeReg(`BLT_REG_SRC_YINC, r.srcYinc);
		writeReg(`BLT_REG_SRC_HI, 16'(r.srcBase[`BLT_ADDR_W-1:16]));
		writeReg(`BLT_REG_SRC_LO, r.srcBase[15:0]);
		writeReg(`BLT_REG_MASK_L, r.maskL);
		writeReg(`BLT_REG_MASK_C, r.maskC);
		writeReg(`BLT_REG_MASK_R, r.maskR);
		writeReg(`BLT_REG_DST_XINC, r.dstXinc);
		writeReg(`BLT_REG_DST_YINC, r.dstYinc);
		writeReg(`BLT_REG_DST_HI, 16'(r.dstBase[`BLT_ADDR_W-1:16]));
		writeReg(`BLT_REG_DST_LO, r.dstBase[15:0]);
		writeReg(`BLT_REG_XCOUNT, r.xCount);
		writeReg(`BLT_REG_YCOUNT, r.yCount);
		writeReg(`BLT_REG_HOPOP, r.hopop);
		ctrl.raw = '0;
		ctrl.f.busy = 1'b1;						// Kicks off the blit
		ctrl.f.lineNum = r.lineNum;
		ctrl.f.skew = r.skew;
		writeReg(`BLT_REG_CTRL, ctrl.raw);
		checkFlag($sformatf("row %0d busy pin after start", n), busy, 1'b1);
		polls = 0;
		do begin
			readReg(`BLT_REG_CTRL, data);
			ctrl.raw = data;
			polls++;
		end while (ctrl.f.busy && polls < 500);
		if (ctrl.f.busy) begin
			$display("Row %0d: blit still busy after %0d status reads", n, polls);
			hung = 1'b1;
		end else begin
			checkFlag($sformatf("row %0d busy pin after end", n), busy, 1'b0);
			expCtrl.raw = '0;
			expCtrl.f.lineNum = r.expLine;
			expCtrl.f.skew = r.skew;
			checkCtrl(ctrl, expCtrl);
			for (int k = 0; k < words; k++)
				checkWord($sformatf("row %0d dst word %0d", n, k),
					mem.peek(walkAddr(r.dstBase, r.dstXinc, r.dstYinc, int'(r.xCount), k)),
					r.expDst[k]);
			readReg(`BLT_REG_SRC_HI, data);
			checkWord($sformatf("row %0d src hi", n), data, 16'(r.expSrcEnd[`BLT_ADDR_W-1:16]));
			readReg(`BLT_REG_SRC_LO, data);
			checkWord($sformatf("row %0d src lo", n), data, r.expSrcEnd[15:0]);
			readReg(`BLT_REG_DST_HI, data);
			checkWord($sformatf("row %0d dst hi", n), data, 16'(r.expDstEnd[`BLT_ADDR_W-1:16]));
			readReg(`BLT_REG_DST_LO, data);
			checkWord($sformatf("row %0d dst lo", n), data, r.expDstEnd[15:0]);
			readReg(`BLT_REG_XCOUNT, data);
			checkWord($sformatf("row %0d x count", n), data, r.xCount);	// Restart value
			readReg(`BLT_REG_YCOUNT, data);
			checkWord($sformatf("row %0d y count", n), data, 16'h0);
		end
	endtask

	initial begin
		logic [15:0] data;
		blitter_pkg::bltCtrlWord expCtrl;
		logic hung;
		errors = 0;
		checks = 0;
		hung = 1'b0;
		regReq = '0;
		reset = 1'b1;
		regTab = {{`BLT_REG_SRC_XINC, 16'h1234, 16'h1234}, {`BLT_REG_SRC_YINC, 16'hFEDC, 16'hFEDC},
			{`BLT_REG_SRC_HI, 16'hFFFF, 16'h007F}, {`BLT_REG_SRC_LO, 16'hA5A5, 16'hA5A5},
			{`BLT_REG_MASK_L, 16'h0F0F, 16'h0F0F}, {`BLT_REG_MASK_C, 16'hF0F0, 16'hF0F0},
			{`BLT_REG_MASK_R, 16'h3C3C, 16'h3C3C}, {`BLT_REG_DST_XINC, 16'h0002, 16'h0002},
			{`BLT_REG_DST_YINC, 16'h8001, 16'h8001}, {`BLT_REG_DST_HI, 16'h0055, 16'h0055},
			{`BLT_REG_DST_LO, 16'h5AA5, 16'h5AA5}, {`BLT_REG_XCOUNT, 16'h0004, 16'h0004},
			{`BLT_REG_YCOUNT, 16'h0003, 16'h0003}, {`BLT_REG_HOPOP, 16'hFFFF, 16'h030F}};
		// OP 15 and OP 0 under partial endmasks, first row reads the destination
		rows[0] = '{16'h0, 16'h0, 16'h1, 16'h1, 16'h0FFF, 16'hFFFF, 16'hFFF0, 16'h000F,
			4'h0, 4'h0, 16'd4, 16'd1, 23'h001000, 23'h002000, {4{16'h0}},
			{16'h1234, 16'h5678, 16'h9ABC, 16'hDEF0}, {16'h0BAD, 16'hBEEF, 16'hF00D, 16'h1F2E},
			{16'h1FFF, 16'hFFFF, 16'hFFFF, 16'hFFF0}, 23'h001000, 23'h002004, 4'h1};
		rows[1] = '{16'h0, 16'h0, 16'h1, 16'h5, 16'h00FF, 16'hFFFF, 16'hFF00, 16'h0000,
			4'h0, 4'h0, 16'd3, 16'd1, 23'h001000, 23'h002010, {4{16'h0}},
			{16'hAAAA, 16'h5555, 16'hC3C3, 16'h0}, {16'h0BAD, 16'hBEEF, 16'hF00D, 16'h1F2E},
			{16'hAA00, 16'h0000, 16'h00C3, 16'h0}, 23'h001000, 23'h002017, 4'h1};
		// Plain copy, then the same copy skewed by 4
		rows[2] = '{16'h1, 16'h1, 16'h1, 16'h1, 16'hFFFF, 16'hFFFF, 16'hFFFF, 16'h0203,
			4'h0, 4'h0, 16'd4, 16'd1, 23'h011000, 23'h002020,
			{16'h1111, 16'h2222, 16'h3333, 16'h4444}, {4{16'h0}},
			{16'h0BAD, 16'hBEEF, 16'hF00D, 16'h1F2E},
			{16'h1111, 16'h2222, 16'h3333, 16'h4444}, 23'h011004, 23'h002024, 4'h1};
		rows[3] = '{16'h1, 16'h1, 16'h1, 16'h1, 16'hFFFF, 16'hFFFF, 16'hFFFF, 16'h0203,
			4'h0, 4'h4, 16'd4, 16'd1, 23'h011000, 23'h002030,
			{16'h1111, 16'h2222, 16'h3333, 16'h4444}, {4{16'h0}},
			{16'h0BAD, 16'hBEEF, 16'hF00D, 16'h1F2E},
			{16'h0111, 16'h1222, 16'h2333, 16'h3444}, 23'h011004, 23'h002034, 4'h1};
		// Halftone only, two lines walking up, then down
		rows[4] = '{16'h0, 16'h0, 16'h1, 16'h7, 16'hFFFF, 16'hFFFF, 16'hFFFF, 16'h0103,
			4'h1, 4'h0, 16'd2, 16'd2, 23'h001000, 23'h002040, {4{16'h0}}, {4{16'h0}},
			{16'h0BAD, 16'hBEEF, 16'hF00D, 16'h1F2E},
			{16'hBEEF, 16'hBEEF, 16'hF00D, 16'hF00D}, 23'h001000, 23'h002050, 4'h3};
		rows[5] = '{16'h0, 16'h0, 16'h1, 16'hFFF9, 16'hFFFF, 16'hFFFF, 16'hFFFF, 16'h0103,
			4'h1, 4'h0, 16'd2, 16'd2, 23'h001000, 23'h002100, {4{16'h0}}, {4{16'h0}},
			{16'h0BAD, 16'hBEEF, 16'hF00D, 16'h1F2E},
			{16'hBEEF, 16'hBEEF, 16'h0BAD, 16'h0BAD}, 23'h001000, 23'h0020F4, 4'hF};
		// Descending source, buffer fills from the high side, skew 8
		rows[6] = '{16'hFFFF, 16'hFFFF, 16'h1, 16'h1, 16'hFFFF, 16'hFFFF, 16'hFFFF, 16'h0203,
			4'h0, 4'h8, 16'd4, 16'd1, 23'h011003, 23'h002060,
			{16'hA1B2, 16'hC3D4, 16'hE5F6, 16'h0718}, {4{16'h0}},
			{16'h0BAD, 16'hBEEF, 16'hF00D, 16'h1F2E},
			{16'hB200, 16'hD4A1, 16'hF6C3, 16'h18E5}, 23'h010FFF, 23'h002064, 4'h1};
		repeat (10) @(posedge Clks);
		#2 reset = 1'b0;

		checkFlag("busy pin after reset", busy, 1'b0);
		for (int i = 0; i < 32; i++) begin		// Everything clear after reset
			readReg(5'(i), data);
			checkWord($sformatf("reset read index %0d", i), data, 16'h0);
		end
		for (int i = 0; i < 14; i++) begin
			writeReg(regTab[i][36:32], regTab[i][31:16]);
			readReg(regTab[i][36:32], data);
			checkWord($sformatf("read-back index %0d", regTab[i][36:32]), data, regTab[i][15:0]);
		end
		for (int i = 0; i < `BLT_HT_DEPTH; i++)
			writeReg(5'(i), 16'(i * 16'h1357) ^ 16'hA0A0);
		for (int i = 0; i < `BLT_HT_DEPTH; i++) begin
			readReg(5'(i), data);
			checkWord($sformatf("halftone %0d", i), data, 16'(i * 16'h1357) ^ 16'hA0A0);
		end
		writeReg(`BLT_REG_CTRL, 16'h7A35);		// Busy clear, reserved bits set
		readReg(`BLT_REG_CTRL, data);
		expCtrl.raw = '0;
		expCtrl.f.lineNum = 4'hA;
		expCtrl.f.skew = 4'h5;
		checkCtrl(data, expCtrl);

		for (int n = 0; n < 7 && !hung; n++)
			runRow(n, hung);

		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0 && !hung)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

/* dv/bltTbMem.sv */
/* Word memory model for the blitter testbench
   Sparse store with address-derived fill, random acknowledge delay,
   peek and poke access for preload and result checks */
`include "blitter_cfg.svh"

module bltTbMem (
	input logic Clks,
	input blitter_pkg::bltMemReq memReq,
	output logic memAck,
	output logic [`BLT_DATA_W-1:0] memRdata
);
	logic [`BLT_DATA_W-1:0] store [logic [`BLT_ADDR_W-1:0]];
	int delay;								// Idle cycles left before the ack
	logic pending;							// Request seen, delay chosen

	// Untouched words hold a pattern built from every address bit
	function automatic logic [`BLT_DATA_W-1:0] fillWord(input logic [`BLT_ADDR_W-1:0] addr);
		return addr[15:0] ^ {addr[22:16], addr[22:14]} ^ 16'h5A3C;
	endfunction

	function automatic logic [`BLT_DATA_W-1:0] peek(input logic [`BLT_ADDR_W-1:0] addr);
		if (store.exists(addr))
			return store[addr];
		return fillWord(addr);
	endfunction

	task automatic poke(input logic [`BLT_ADDR_W-1:0] addr, input logic [`BLT_DATA_W-1:0] data);
		store[addr] = data;
	endtask

	initial begin
		memAck = 1'b0;
		memRdata = '0;
		pending = 1'b0;
		delay = $urandom(23434);			// Seed once for the whole run
		forever begin
			@(posedge Clks);
			#2;
			if (memAck) begin
				memAck = 1'b0;				// One-cycle pulse
				pending = 1'b0;
			end else if (memReq.valid) begin
				if (!pending) begin
					pending = 1'b1;
					delay = $urandom % 6;	// 0 to 5 idle cycles
				end
				if (delay == 0) begin
					if (memReq.write)
						store[memReq.addr] = memReq.wdata;
					else
						memRdata = peek(memReq.addr);
					memAck = 1'b1;
				end else begin
					delay--;
				end
			end
		end
	end

endmodule

/* source/stBlitterTop.sv */
/* Blitter top level
   Register file, address generator, skew buffer, sequencer and
   logic op unit on a CPU register port and a memory request port */
`include "blitter_cfg.svh"

module stBlitterTop (
	input logic Clks,
	input logic reset,
	input blitter_pkg::bltRegReq regReq,
	output logic [`BLT_DATA_W-1:0] regRdata,
	output blitter_pkg::bltMemReq memReq,
	input logic memAck,
	input logic [`BLT_DATA_W-1:0] memRdata,
	output logic busy
);
	blitter_pkg::bltConfig cfg;
	blitter_pkg::bltStep step;
	logic [3:0] lineNum;
	logic start;
	logic blitDone;
	logic lineStep;
	logic lastX;
	logic lastY;
	logic needSrc;
	logic needDst;
	logic [`BLT_ADDR_W-1:0] srcAddr;
	logic [`BLT_ADDR_W-1:0] dstAddr;
	logic [1:0][15:0] counts;
	logic [`BLT_DATA_W-1:0] htRdata;
	logic [`BLT_DATA_W-1:0] srcWord;
	logic [`BLT_DATA_W-1:0] result;

	bltRegFile regFile (.Clks, .reset, .regReq, .regRdata, .blitDone, .lineStep, .htRdata,
		.cntRdata(counts), .addrRdata({srcAddr, dstAddr}), .cfg, .lineNum, .busy, .start);

	bltAddrGen addrGen (.Clks, .reset, .regReq, .cfg, .step, .srcAddr, .dstAddr,
		.counts, .lastX, .lastY);

	bltSkewBuf skewBuf (.Clks, .reset, .start, .srcDone(step.srcDone), .memRdata,
		.direction(cfg.srcXinc[15]), .skew(cfg.skew), .srcWord);

	bltSequencer sequencer (.Clks, .reset, .start, .busy, .needSrc, .needDst, .lastX, .lastY,
		.srcAddr, .dstAddr, .result, .memReq, .memAck, .step, .blitDone, .lineStep);

	bltLogicOp logicOp (.Clks, .reset, .regReq, .cfg, .lineNum, .step, .lastX, .srcWord,
		.memRdata, .htRdata, .needSrc, .needDst, .result);

endmodule

/* source/bltLogicOp.sv */
/* Blitter logic op unit
   Halftone RAM with CPU port, endmask selection,
   HOP source combine, 16 OP truth table and masked merge */
`include "blitter_cfg.svh"

module bltLogicOp (
	input logic Clks,
	input logic reset,
	input blitter_pkg::bltRegReq regReq,
	input blitter_pkg::bltConfig cfg,
	input logic [3:0] lineNum,
	input blitter_pkg::bltStep step,
	input logic lastX,
	input logic [`BLT_DATA_W-1:0] srcWord,
	input logic [`BLT_DATA_W-1:0] memRdata,
	output logic [`BLT_DATA_W-1:0] htRdata,
	output logic needSrc,
	output logic needDst,
	output logic [`BLT_DATA_W-1:0] result
);
	logic [`BLT_DATA_W-1:0] htRam [`BLT_HT_DEPTH];
	logic [`BLT_DATA_W-1:0] htWord;			// Halftone for current word
	logic [`BLT_DATA_W-1:0] dstWord;		// Old destination
	logic [`BLT_DATA_W-1:0] mask;
	logic [`BLT_DATA_W-1:0] hopWord;
	logic [`BLT_DATA_W-1:0] opWord;
	logic newLine;							// Next word is the first of a line

	// Halftone RAM, cleared so read-back after reset is zero
	always_ff @(posedge Clks) begin
		if (reset) begin
			for (int i = 0; i < `BLT_HT_DEPTH; i++)
				htRam[i] <= '0;
		end else if (regReq.wr && !regReq.idx[4]) begin
			htRam[regReq.idx[3:0]] <= regReq.wdata;
		end
	end
	assign htRdata = htRam[regReq.idx[3:0]];	// CPU read port

	always_ff @(posedge Clks) begin
		if (step.start)
			htWord <= htRam[lineNum];
		if (step.dstDone)
			dstWord <= memRdata;
	end

	always_ff @(posedge Clks) begin
		if (reset || (regReq.wr && regReq.idx == `BLT_REG_CTRL && regReq.wdata[15]))
			newLine <= 1'b1;
		else if (step.wrDone)
			newLine <= lastX;
	end

	// Left wins on one-word lines
	assign mask = newLine ? cfg.maskL : (lastX ? cfg.maskR : cfg.maskC);

	// HOP 0 ones, 1 halftone, 2 source, 3 both
	assign hopWord = (cfg.hop[1] ? srcWord : '1) & (cfg.hop[0] ? htWord : '1);

	always_comb begin
		for (int i = 0; i < `BLT_DATA_W; i++)
			opWord[i] = cfg.op[{~hopWord[i], ~dstWord[i]}];	// Bit 0 for S=1 D=1
	end

	assign result = (opWord & mask) | (dstWord & ~mask);
	assign needSrc = cfg.hop[1] & ((cfg.op[3:2] != cfg.op[1:0]));	// OP 0,5,A,F ignore S
	assign needDst = (cfg.op[3] ^ cfg.op[2]) | (cfg.op[1] ^ cfg.op[0]) | ~&mask;

endmodule

/* source/bltSequencer.sv */
/* Blitter bus sequencer
   Per-word read source, read destination, write destination cycles,
   memory request generation, line and blit completion */
`include "blitter_cfg.svh"

module bltSequencer (
	input logic Clks,
	input logic reset,
	input logic start,
	input logic busy,
	input logic needSrc,
	input logic needDst,
	input logic lastX,
	input logic lastY,
	input logic [`BLT_ADDR_W-1:0] srcAddr,
	input logic [`BLT_ADDR_W-1:0] dstAddr,
	input logic [`BLT_DATA_W-1:0] result,
	output blitter_pkg::bltMemReq memReq,
	input logic memAck,
	output blitter_pkg::bltStep step,
	output logic blitDone,
	output logic lineStep
);
	blitter_pkg::bltCycle cyc;
	blitter_pkg::bltCycle first;			// Opening cycle of the next word
	blitter_pkg::bltCycle afterSrc;
	logic active;							// Blit running, set by start
	logic gap;								// Request low for one cycle after each ack
	logic ack;
	logic wordBegin;

	assign ack = memAck & memReq.valid;
	assign wordBegin = (cyc == blitter_pkg::IDLE) & busy & (start | active);

	// Skip reads the OP, HOP or mask do not need
	always_comb begin
		if (needSrc)
			first = blitter_pkg::RDSRC;
		else if (needDst)
			first = blitter_pkg::RDDST;
		else
			first = blitter_pkg::WRDST;
		afterSrc = needDst ? blitter_pkg::RDDST : blitter_pkg::WRDST;
	end

	assign memReq.valid = (cyc != blitter_pkg::IDLE) & !gap;
	assign memReq.write = (cyc == blitter_pkg::WRDST);
	assign memReq.addr = (cyc == blitter_pkg::RDSRC) ? srcAddr : dstAddr;
	assign memReq.wdata = result;

	assign step.start = wordBegin;
	assign step.srcDone = ack & (cyc == blitter_pkg::RDSRC);
	assign step.dstDone = ack & (cyc == blitter_pkg::RDDST);
	assign step.wrDone = ack & (cyc == blitter_pkg::WRDST);
	assign lineStep = step.wrDone & lastX;			// Last word of a line written
	assign blitDone = step.wrDone & lastX & lastY;

	always_ff @(posedge Clks) begin
		if (reset) begin
			cyc <= blitter_pkg::IDLE;
			gap <= 1'b0;
			active <= 1'b0;
		end else begin
			gap <= ack;
			active <= start | (active & busy & !blitDone);
			case (cyc)
				blitter_pkg::IDLE:
					if (wordBegin)
						cyc <= first;
				blitter_pkg::RDSRC:						// Busy cleared ends after this transfer
					if (ack)
						cyc <= busy ? afterSrc : blitter_pkg::IDLE;
				blitter_pkg::RDDST:
					if (ack)
						cyc <= busy ? blitter_pkg::WRDST : blitter_pkg::IDLE;
				blitter_pkg::WRDST:
					if (ack)
						cyc <= blitter_pkg::IDLE;		// Next word decided with fresh counters
				default:
					cyc <= blitter_pkg::IDLE;
			endcase
		end
	end

endmodule

/* source/bltSkewBuf.sv */
/* Blitter source skew buffer
   Previous and current source words, filled from the side given by
   the source X direction, barrel shifted right by skew */
`include "blitter_cfg.svh"

module bltSkewBuf (
	input logic Clks,
	input logic reset,
	input logic start,
	input logic srcDone,
	input logic [`BLT_DATA_W-1:0] memRdata,
	input logic direction,					// Source X increment sign
	input logic [3:0] skew,
	output logic [`BLT_DATA_W-1:0] srcWord
);
	logic [2*`BLT_DATA_W-1:0] pair;			// Two words in flight
	logic [2*`BLT_DATA_W-1:0] shifted;

	always_ff @(posedge Clks) begin
		if (reset || start) begin
			pair <= '0;						// Fresh blit starts empty
		end else if (srcDone) begin
			if (direction)
				pair <= {memRdata, pair[2*`BLT_DATA_W-1:`BLT_DATA_W]};	// Descending, enters high
			else
				pair <= {pair[`BLT_DATA_W-1:0], memRdata};				// Ascending, enters low
		end
	end

	assign shifted = pair >> skew;
	assign srcWord = shifted[`BLT_DATA_W-1:0];	// Low half feeds the logic op

endmodule

/* source/bltAddrGen.sv */
/* Blitter address generator
   X/Y word counters with X restart value, source and destination
   address registers, increment selection per line position */
`include "blitter_cfg.svh"

module bltAddrGen (
	input logic Clks,
	input logic reset,
	input blitter_pkg::bltRegReq regReq,
	input blitter_pkg::bltConfig cfg,
	input blitter_pkg::bltStep step,
	output logic [`BLT_ADDR_W-1:0] srcAddr,
	output logic [`BLT_ADDR_W-1:0] dstAddr,
	output logic [1:0][15:0] counts,
	output logic lastX,
	output logic lastY
);
	logic [15:0] xCount;
	logic [15:0] xStart;					// X count reloaded at each line end
	logic [15:0] yCount;
	logic [15:0] srcInc;
	logic [15:0] dstInc;
	logic [`BLT_ADDR_W-1:0] srcStep;
	logic [`BLT_ADDR_W-1:0] dstStep;

	assign lastX = (xCount == 16'd1);
	assign lastY = (yCount == 16'd1);
	assign counts = {xCount, yCount};

	// Y increment on the last word of a line, X otherwise
	assign srcInc = lastX ? cfg.srcYinc : cfg.srcXinc;
	assign dstInc = lastX ? cfg.dstYinc : cfg.dstXinc;
	assign srcStep = {{(`BLT_ADDR_W-16){srcInc[15]}}, srcInc};		// Sign extend
	assign dstStep = {{(`BLT_ADDR_W-16){dstInc[15]}}, dstInc};

	always_ff @(posedge Clks) begin
		if (reset) begin
			xCount <= '0;
			xStart <= '0;
			yCount <= '0;
		end else begin
			if (regReq.wr && regReq.idx == `BLT_REG_XCOUNT) begin
				xCount <= regReq.wdata;
				xStart <= regReq.wdata;
			end else if (step.wrDone) begin
				xCount <= lastX ? xStart : xCount - 16'd1;
			end
			if (regReq.wr && regReq.idx == `BLT_REG_YCOUNT)
				yCount <= regReq.wdata;
			else if (step.wrDone && lastX)
				yCount <= yCount - 16'd1;			// One line finished
		end
	end

	// Source moves per source read, destination per write
	always_ff @(posedge Clks) begin
		if (reset) begin
			srcAddr <= '0;
			dstAddr <= '0;
		end else begin
			if (regReq.wr && regReq.idx == `BLT_REG_SRC_HI)
				srcAddr[`BLT_ADDR_W-1:16] <= regReq.wdata[`BLT_ADDR_W-17:0];
			else if (regReq.wr && regReq.idx == `BLT_REG_SRC_LO)
				srcAddr[15:0] <= regReq.wdata;
			else if (step.srcDone)
				srcAddr <= srcAddr + srcStep;

			if (regReq.wr && regReq.idx == `BLT_REG_DST_HI)
				dstAddr[`BLT_ADDR_W-1:16] <= regReq.wdata[`BLT_ADDR_W-17:0];
			else if (regReq.wr && regReq.idx == `BLT_REG_DST_LO)
				dstAddr[15:0] <= regReq.wdata;
			else if (step.wrDone)
				dstAddr <= dstAddr + dstStep;
		end
	end

endmodule

/* source/bltRegFile.sv */
/* Blitter register file
   Increments, endmasks, HOP/OP, control/status word, line counter
   and the registered CPU read-back mux */
`include "blitter_cfg.svh"

module bltRegFile (
	input logic Clks,
	input logic reset,
	input blitter_pkg::bltRegReq regReq,
	output logic [`BLT_DATA_W-1:0] regRdata,
	input logic blitDone,
	input logic lineStep,
	input logic [`BLT_DATA_W-1:0] htRdata,
	input logic [1:0][15:0] cntRdata,				// [1] X count, [0] Y count
	input logic [1:0][`BLT_ADDR_W-1:0] addrRdata,	// [1] source, [0] destination
	output blitter_pkg::bltConfig cfg,
	output logic [3:0] lineNum,
	output logic busy,
	output logic start
);
	blitter_pkg::bltCtrlWord ctrlWr;		// Incoming control write
	blitter_pkg::bltCtrlWord ctrlRd;		// Status for read-back
	logic regWr;
	logic ctrlHit;
	logic [`BLT_DATA_W-1:0] rdMux;

	assign regWr = regReq.wr & regReq.idx[4];				// Upper half is registers
	assign ctrlHit = regReq.wr & (regReq.idx == `BLT_REG_CTRL);
	assign ctrlWr.raw = regReq.wdata;

	// Datapath registers, writable even mid-blit
	always_ff @(posedge Clks) begin
		if (reset) begin
			cfg <= '0;
		end else if (regWr) begin
			case (regReq.idx)
				`BLT_REG_SRC_XINC:	cfg.srcXinc <= regReq.wdata;
				`BLT_REG_SRC_YINC:	cfg.srcYinc <= regReq.wdata;
				`BLT_REG_DST_XINC:	cfg.dstXinc <= regReq.wdata;
				`BLT_REG_DST_YINC:	cfg.dstYinc <= regReq.wdata;
				`BLT_REG_MASK_L:	cfg.maskL <= regReq.wdata;
				`BLT_REG_MASK_C:	cfg.maskC <= regReq.wdata;
				`BLT_REG_MASK_R:	cfg.maskR <= regReq.wdata;
				`BLT_REG_HOPOP: begin
					cfg.hop <= regReq.wdata[9:8];
					cfg.op <= regReq.wdata[3:0];
				end
				`BLT_REG_CTRL:		cfg.skew <= ctrlWr.f.skew;
				default: ;
			endcase
		end
	end

	// Busy flag, start pulse and halftone line counter
	always_ff @(posedge Clks) begin
		if (reset) begin
			busy <= 1'b0;
			start <= 1'b0;
			lineNum <= '0;
		end else begin
			start <= ctrlHit & ctrlWr.f.busy;		// Only a write with busy set kicks off
			if (ctrlHit) begin
				busy <= ctrlWr.f.busy;			// Writing 0 stops after current transfer
				lineNum <= ctrlWr.f.lineNum;
			end else begin
				if (blitDone)
					busy <= 1'b0;
				if (lineStep)					// Walk up or down with dest Y direction
					lineNum <= cfg.dstYinc[15] ? lineNum - 4'd1 : lineNum + 4'd1;
			end
		end
	end

	always_comb begin
		ctrlRd.raw = '0;
		ctrlRd.f.busy = busy;
		ctrlRd.f.lineNum = lineNum;
		ctrlRd.f.skew = cfg.skew;
		rdMux = '0;
		if (!regReq.idx[4]) begin
			rdMux = htRdata;					// Halftone RAM
		end else begin
			case (regReq.idx)
				`BLT_REG_SRC_XINC:	rdMux = cfg.srcXinc;
				`BLT_REG_SRC_YINC:	rdMux = cfg.srcYinc;
				`BLT_REG_SRC_HI:	rdMux = 16'(addrRdata[1][`BLT_ADDR_W-1:16]);
				`BLT_REG_SRC_LO:	rdMux = addrRdata[1][15:0];
				`BLT_REG_MASK_L:	rdMux = cfg.maskL;
				`BLT_REG_MASK_C:	rdMux = cfg.maskC;
				`BLT_REG_MASK_R:	rdMux = cfg.maskR;
				`BLT_REG_DST_XINC:	rdMux = cfg.dstXinc;
				`BLT_REG_DST_YINC:	rdMux = cfg.dstYinc;
				`BLT_REG_DST_HI:	rdMux = 16'(addrRdata[0][`BLT_ADDR_W-1:16]);
				`BLT_REG_DST_LO:	rdMux = addrRdata[0][15:0];
				`BLT_REG_XCOUNT:	rdMux = cntRdata[1];
				`BLT_REG_YCOUNT:	rdMux = cntRdata[0];
				`BLT_REG_HOPOP:		rdMux = {6'b0, cfg.hop, 4'b0, cfg.op};
				`BLT_REG_CTRL:		rdMux = ctrlRd.raw;
				default:			rdMux = '0;			// Index 31 unused
			endcase
		end
	end

	// Read data valid the cycle after the strobe
	always_ff @(posedge Clks) begin
		if (reset)
			regRdata <= '0;
		else if (regReq.rd)
			regRdata <= rdMux;
	end

endmodule

/* source/blitter_pkg.sv */
/* Blitter shared types
   CPU and memory requests, control word union,
   datapath config bundle, sequencer states and step strobes */
`include "blitter_cfg.svh"

package blitter_pkg;

	// CPU register port access
	typedef struct packed {
		logic wr;							// Write strobe
		logic rd;							// Read strobe, data next cycle
		logic [`BLT_REG_IDX_W-1:0] idx;
		logic [`BLT_DATA_W-1:0] wdata;
	} bltRegReq;

	// Memory side request, held until acknowledged
	typedef struct packed {
		logic valid;
		logic write;
		logic [`BLT_ADDR_W-1:0] addr;
		logic [`BLT_DATA_W-1:0] wdata;
	} bltMemReq;

	typedef struct packed {
		logic busy;							// Write 1 starts, reads 1 while running
		logic [2:0] rsvdHi;					// HOG/SMUDGE slots, unused here
		logic [3:0] lineNum;				// Halftone line
		logic [3:0] rsvdLo;					// FXSR/NFSR slots
		logic [3:0] skew;
	} bltCtrlFields;

	// Control word seen as a raw bus word or as fields
	typedef union packed {
		logic [`BLT_DATA_W-1:0] raw;
		bltCtrlFields f;
	} bltCtrlWord;

	// Registers the datapath reads
	typedef struct packed {
		logic [15:0] srcXinc;				// Signed word increments
		logic [15:0] srcYinc;
		logic [15:0] dstXinc;
		logic [15:0] dstYinc;
		logic [15:0] maskL;
		logic [15:0] maskC;
		logic [15:0] maskR;
		logic [1:0] hop;
		logic [3:0] op;
		logic [3:0] skew;
	} bltConfig;

	typedef enum logic [1:0] { IDLE, RDSRC, RDDST, WRDST } bltCycle;

	// One-cycle strobes from the sequencer
	typedef struct packed {
		logic start;						// Word begins, latch halftone
		logic srcDone;						// Source word arrived
		logic dstDone;						// Destination read latched
		logic wrDone;						// Destination word written
	} bltStep;

endpackage

/* include/blitter_cfg.svh */
/* Blitter build configuration
   Bus widths, halftone depth and the CPU register index map */
`ifndef BLITTER_CFG_SVH
`define BLITTER_CFG_SVH

`define BLT_ADDR_W		23		// Word address
`define BLT_DATA_W		16
`define BLT_REG_IDX_W	5		// 0..15 halftone, 16..31 registers
`define BLT_HT_DEPTH	16

// Register indices, same order as the original register block
`define BLT_REG_SRC_XINC	5'd16
`define BLT_REG_SRC_YINC	5'd17
`define BLT_REG_SRC_HI		5'd18
`define BLT_REG_SRC_LO		5'd19
`define BLT_REG_MASK_L		5'd20
`define BLT_REG_MASK_C		5'd21
`define BLT_REG_MASK_R		5'd22
`define BLT_REG_DST_XINC	5'd23
`define BLT_REG_DST_YINC	5'd24
`define BLT_REG_DST_HI		5'd25
`define BLT_REG_DST_LO		5'd26
`define BLT_REG_XCOUNT		5'd27
`define BLT_REG_YCOUNT		5'd28
`define BLT_REG_HOPOP		5'd29
`define BLT_REG_CTRL		5'd30

`endif
